// File: verif/xbar_golden.txt
// Columns: channel opcode address data stall bank (all hex).
// Stall lines are sent while every bank holds ready low.
0 1 00001010 a0000000000000000000000000000001 1 1
0 1 00001050 a0000000000000000000000000000002 1 1
0 0 00001090 a0000000000000000000000000000003 1 1
0 1 000010d0 a0000000000000000000000000000004 1 1
0 2 00002010 a0000000000000000000000000000005 1 1
0 1 00002050 a0000000000000000000000000000006 1 1
0 3 00002090 a0000000000000000000000000000007 1 1
0 1 000020d0 a0000000000000000000000000000008 1 1
0 4 00003010 a0000000000000000000000000000009 1 1
0 1 00003050 a000000000000000000000000000000a 1 1
1 1 00011010 b0000000000000000000000000000001 1 1
1 0 00011050 b0000000000000000000000000000002 1 1
1 5 00011090 b0000000000000000000000000000003 1 1
2 0 00020000 c0000000000000000000000000000001 0 0
2 1 00020020 c0000000000000000000000000000002 0 2
0 2 00000030 a000000000000000000000000000000b 0 3
1 0 00011000 b0000000000000000000000000000004 0 0
2 3 00020030 c0000000000000000000000000000003 0 3
0 1 00000120 a000000000000000000000000000000c 0 2
1 4 00011130 b0000000000000000000000000000005 0 3
2 5 00020110 c0000000000000000000000000000004 0 1
0 0 00000200 a000000000000000000000000000000d 0 0
1 1 00011220 b0000000000000000000000000000006 0 2
2 2 00020310 c0000000000000000000000000000005 0 1

// File: vlog.f
+incdir+source
source/mpc_types.sv
source/xbar_pkg.sv
source/xbar_ifs.sv
source/xbar_ingress.sv
source/xbar_sub_buffer.sv
source/xbar_bank_arbiter.sv
source/xbar_buffer.sv
verif/xbar_asserts.sv
verif/xbar_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= xbar_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -Wno-fatal --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/xbar_tb.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

module xbar_tb
    import mpc_types::*;
();

localparam int NREC = 24;
localparam int NFLD = 6;

logic        clk = 1'b0;
logic        rst_n = 1'b0;
logic        ch_valid [3];
logic        ch_ready [3];
mpc_op_e     ch_op    [3];
logic [31:0] ch_addr  [3];
logic [127:0] ch_data [3];
logic        bank_valid [4];
logic        bank_ready [4];
mpc_op_e     bank_op    [4];
logic [31:0] bank_addr  [4];
logic [127:0] bank_data [4];
logic [1:0]  bank_src   [4];

logic [127:0] gold_mem [NREC*NFLD];
int          rec_ch    [NREC];
logic [2:0]  rec_op    [NREC];
logic [31:0] rec_addr  [NREC];
logic [127:0] rec_data [NREC];
bit          rec_stall [NREC];
int          rec_bank  [NREC];

// One queue of record indices per (channel, bank) pair, in arrival order.
int          exp_q [12][$];
bit          stall = 1'b1;
bit          fair_on = 1'b0;
int          fair_cnt = 0;
bit          held [4];
logic [31:0] held_addr [4];
logic [127:0] held_data [4];

always #10 clk = ~clk;

xbar_buffer i_dut (
    .clk (clk), .rst_n (rst_n),
    .ch_0_valid (ch_valid[0]), .ch_0_ready (ch_ready[0]), .ch_0_op (ch_op[0]),
    .ch_0_addr (ch_addr[0]), .ch_0_data (ch_data[0]),
    .ch_1_valid (ch_valid[1]), .ch_1_ready (ch_ready[1]), .ch_1_op (ch_op[1]),
    .ch_1_addr (ch_addr[1]), .ch_1_data (ch_data[1]),
    .ch_2_valid (ch_valid[2]), .ch_2_ready (ch_ready[2]), .ch_2_op (ch_op[2]),
    .ch_2_addr (ch_addr[2]), .ch_2_data (ch_data[2]),
    .bank_0_valid (bank_valid[0]), .bank_0_ready (bank_ready[0]), .bank_0_op (bank_op[0]),
    .bank_0_addr (bank_addr[0]), .bank_0_data (bank_data[0]), .bank_0_src (bank_src[0]),
    .bank_1_valid (bank_valid[1]), .bank_1_ready (bank_ready[1]), .bank_1_op (bank_op[1]),
    .bank_1_addr (bank_addr[1]), .bank_1_data (bank_data[1]), .bank_1_src (bank_src[1]),
    .bank_2_valid (bank_valid[2]), .bank_2_ready (bank_ready[2]), .bank_2_op (bank_op[2]),
    .bank_2_addr (bank_addr[2]), .bank_2_data (bank_data[2]), .bank_2_src (bank_src[2]),
    .bank_3_valid (bank_valid[3]), .bank_3_ready (bank_ready[3]), .bank_3_op (bank_op[3]),
    .bank_3_addr (bank_addr[3]), .bank_3_data (bank_data[3]), .bank_3_src (bank_src[3])
);

// ------------------------------
// Reporting
// ------------------------------

task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input logic [127:0] exp, input logic [127:0] act);
    assert (exp === act)
    else
    begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        stop_run("value mismatch");
    end
endtask

function automatic int pending_count();
    int n;
    n = 0;
    for (int k = 0; k < 12; k++)
        n += exp_q[k].size();
    return n;
endfunction

// ------------------------------
// Channel drivers
// ------------------------------

// Called on a falling edge. Leaves valid high if the limit runs out.
task automatic send_request(input int c, input int idx, input int limit, output bit accepted);
    int waited;
    waited = 0;
    ch_valid[c] = 1'b1;
    ch_op[c]    = mpc_op_e'(rec_op[idx]);
    ch_addr[c]  = rec_addr[idx];
    ch_data[c]  = rec_data[idx];
    while (!ch_ready[c] && waited < limit)
    begin
        @(negedge clk);
        waited++;
    end
    accepted = ch_ready[c];
    if (accepted)
    begin
        @(posedge clk);
        exp_q[c*4 + rec_bank[idx]].push_back(idx);
        @(negedge clk);
        ch_valid[c] = 1'b0;
    end
endtask

task automatic send_channel(input int c);
    bit acc;
    for (int i = 0; i < NREC; i++)
    begin
        if (rec_ch[i] == c && !rec_stall[i])
        begin
            send_request(c, i, 2000, acc);
            assert (acc) else stop_run("channel ready stayed low until the timeout");
        end
    end
endtask

// ------------------------------
// Bank model and output checks
// ------------------------------

task automatic check_output(input int b);
    int src;
    int idx;
    src = int'(bank_src[b]);
    assert (src < 3) else stop_run("bank output names a channel that does not exist");
    assert (exp_q[src*4 + b].size() > 0) else stop_run("unexpected or duplicate bank output");
    idx = exp_q[src*4 + b].pop_front();
    check_value("route_addr_bank", bank_addr[b][5:4], b);
    check_value("order_op", rec_op[idx], bank_op[b]);
    check_value("order_addr", rec_addr[idx], bank_addr[b]);
    check_value("order_data", rec_data[idx], bank_data[b]);
    if (b == 1 && fair_on && fair_cnt < 6)
    begin
        check_value("fairness_src", fair_cnt % 2, src);
        fair_cnt++;
    end
endtask

always @(negedge clk)
begin
    if (rst_n)
    begin
        for (int b = 0; b < 4; b++)
        begin
            if (held[b])
            begin
                assert (bank_valid[b]) else stop_run("bank valid dropped while stalled");
                check_value("held_addr", held_addr[b], bank_addr[b]);
                check_value("held_data", held_data[b], bank_data[b]);
            end
            bank_ready[b] = stall ? 1'b0 : (($urandom % 4) != 0);
            held[b]       = bank_valid[b] && !bank_ready[b];
            held_addr[b]  = bank_addr[b];
            held_data[b]  = bank_data[b];
            if (bank_valid[b] && bank_ready[b])
                check_output(b);
        end
    end
end

task automatic check_idle(input string name);
    for (int b = 0; b < 4; b++)
        check_value({name, "_bank_valid"}, 0, bank_valid[b]);
    for (int c = 0; c < 3; c++)
        check_value({name, "_ch_ready"}, 1, ch_ready[c]);
endtask

// ------------------------------
// Main sequence
// ------------------------------

initial
begin : main
    bit acc;
    int count;
    int waited;
    void'($urandom(31));
    for (int c = 0; c < 3; c++)
    begin
        ch_valid[c] = 1'b0;
        ch_op[c]    = MPC_OP_READ;
        ch_addr[c]  = '0;
        ch_data[c]  = '0;
    end
    for (int b = 0; b < 4; b++)
    begin
        bank_ready[b] = 1'b0;
        held[b]       = 1'b0;
    end

    $readmemh("verif/xbar_golden.txt", gold_mem);
    for (int i = 0; i < NREC; i++)
    begin
        assert (!$isunknown(gold_mem[i*NFLD]) && gold_mem[i*NFLD] < 3)
            else stop_run("golden file is missing or has a bad channel field");
        rec_ch[i]    = int'(gold_mem[i*NFLD]);
        rec_op[i]    = gold_mem[i*NFLD + 1][2:0];
        rec_addr[i]  = gold_mem[i*NFLD + 2][31:0];
        rec_data[i]  = gold_mem[i*NFLD + 3];
        rec_stall[i] = gold_mem[i*NFLD + 4][0];
        rec_bank[i]  = int'(gold_mem[i*NFLD + 5][1:0]);
    end

    repeat (2)
    begin
        @(negedge clk);
        check_idle("reset");
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_idle("after_reset");

    // Stall phase. Channel 0 offers ten requests and may take only nine.
    count = 0;
    for (int i = 0; i < NREC; i++)
    begin
        if (rec_stall[i] && rec_ch[i] == 0)
        begin
            send_request(0, i, 16, acc);
            if (acc)
                count++;
        end
    end
    check_value("stall_accept_count", 9, count);
    check_value("stall_ch_ready", 0, ch_ready[0]);
    for (int i = 0; i < NREC; i++)
    begin
        if (rec_stall[i] && rec_ch[i] == 1)
        begin
            send_request(1, i, 16, acc);
            assert (acc) else stop_run("channel 1 refused a request during the stall");
        end
    end

    // The stall ends between two updates of the bank model.
    @(posedge clk);
    stall   = 1'b0;
    fair_on = 1'b1;
    @(negedge clk);
    send_request(0, 9, 2000, acc);
    assert (acc) else stop_run("blocked channel 0 request never accepted");

    // Channel 2 also targets bank 1, so it starts only after the alternation.
    waited = 0;
    while (fair_cnt < 6 && waited < 2000)
    begin
        @(negedge clk);
        waited++;
    end
    assert (fair_cnt == 6) else stop_run("fairness grants on bank 1 timed out");

    fork
        send_channel(0);
        send_channel(1);
        send_channel(2);
    join

    waited = 0;
    while (pending_count() > 0 && waited < 2000)
    begin
        @(negedge clk);
        waited++;
    end
    check_value("drain_pending", 0, pending_count());

    $display("Done: no errors");
    $finish;
end

endmodule

// File: verif/xbar_asserts.sv
`timescale 1ns/1ps

module xbar_asserts
(
    input logic              clk,
    input logic              rst_n,
    input logic [3:0]        valid,
    input logic [3:0]        ready,
    input logic [3:0][31:0]  addr,
    input logic [3:0][127:0] data
);

for (genvar b = 0; b < 4; b++)
begin : bank_gen
    // A stalled output keeps valid high until it is taken.
    hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid[b] && !ready[b] |=> valid[b])
        else $error("bank valid dropped before its handshake");

    hold_payload: assert property (@(posedge clk) disable iff (!rst_n)
        valid[b] && !ready[b] |=> $stable(addr[b]) && $stable(data[b]))
        else $error("bank payload changed before its handshake");
end

reset_idle: assert property (@(posedge clk) !rst_n |-> valid == 4'b0)
    else $error("bank valid high during reset");

endmodule

bind xbar_buffer xbar_asserts i_xbar_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .valid ({bank_3_valid, bank_2_valid, bank_1_valid, bank_0_valid}),
    .ready ({bank_3_ready, bank_2_ready, bank_1_ready, bank_0_ready}),
    .addr  ({bank_3_addr, bank_2_addr, bank_1_addr, bank_0_addr}),
    .data  ({bank_3_data, bank_2_data, bank_1_data, bank_0_data})
);

// File: source/xbar_buffer.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

module xbar_buffer
    import mpc_types::*;
(
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           ch_0_valid,
    output logic                           ch_0_ready,
    input  mpc_op_e                        ch_0_op,
    input  logic [`MPC_ADDR_W-1:0]         ch_0_addr,
    input  logic [`MPC_DATA_W-1:0]         ch_0_data,

    input  logic                           ch_1_valid,
    output logic                           ch_1_ready,
    input  mpc_op_e                        ch_1_op,
    input  logic [`MPC_ADDR_W-1:0]         ch_1_addr,
    input  logic [`MPC_DATA_W-1:0]         ch_1_data,

    input  logic                           ch_2_valid,
    output logic                           ch_2_ready,
    input  mpc_op_e                        ch_2_op,
    input  logic [`MPC_ADDR_W-1:0]         ch_2_addr,
    input  logic [`MPC_DATA_W-1:0]         ch_2_data,

    output logic                           bank_0_valid,
    input  logic                           bank_0_ready,
    output mpc_op_e                        bank_0_op,
    output logic [`MPC_ADDR_W-1:0]         bank_0_addr,
    output logic [`MPC_DATA_W-1:0]         bank_0_data,
    output logic [$clog2(`MPC_NUM_CH)-1:0] bank_0_src,

    output logic                           bank_1_valid,
    input  logic                           bank_1_ready,
    output mpc_op_e                        bank_1_op,
    output logic [`MPC_ADDR_W-1:0]         bank_1_addr,
    output logic [`MPC_DATA_W-1:0]         bank_1_data,
    output logic [$clog2(`MPC_NUM_CH)-1:0] bank_1_src,

    output logic                           bank_2_valid,
    input  logic                           bank_2_ready,
    output mpc_op_e                        bank_2_op,
    output logic [`MPC_ADDR_W-1:0]         bank_2_addr,
    output logic [`MPC_DATA_W-1:0]         bank_2_data,
    output logic [$clog2(`MPC_NUM_CH)-1:0] bank_2_src,

    output logic                           bank_3_valid,
    input  logic                           bank_3_ready,
    output mpc_op_e                        bank_3_op,
    output logic [`MPC_ADDR_W-1:0]         bank_3_addr,
    output logic [`MPC_DATA_W-1:0]         bank_3_data,
    output logic [$clog2(`MPC_NUM_CH)-1:0] bank_3_src
);

logic                           ch_valid   [`MPC_NUM_CH];
logic                           ch_ready   [`MPC_NUM_CH];
mpc_req_t                       ch_req     [`MPC_NUM_CH];
logic                           bank_valid [`MPC_NUM_BANK];
logic                           bank_ready [`MPC_NUM_BANK];
mpc_req_t                       bank_req   [`MPC_NUM_BANK];
logic [$clog2(`MPC_NUM_CH)-1:0] bank_src   [`MPC_NUM_BANK];

ch_wr_if wr_if [`MPC_NUM_CH] ();
ch_rd_if rd_if [`MPC_NUM_CH] ();

// ------------------------------
// Channel side
// ------------------------------

assign ch_valid[0] = ch_0_valid;
assign ch_valid[1] = ch_1_valid;
assign ch_valid[2] = ch_2_valid;
assign ch_0_ready  = ch_ready[0];
assign ch_1_ready  = ch_ready[1];
assign ch_2_ready  = ch_ready[2];

assign ch_req[0] = '{op: ch_0_op, addr: mpc_addr_u'(ch_0_addr), data: ch_0_data};
assign ch_req[1] = '{op: ch_1_op, addr: mpc_addr_u'(ch_1_addr), data: ch_1_data};
assign ch_req[2] = '{op: ch_2_op, addr: mpc_addr_u'(ch_2_addr), data: ch_2_data};

xbar_ingress u_xbar_ingress (
    .clk      (clk),
    .rst_n    (rst_n),
    .ch_valid (ch_valid),
    .ch_req   (ch_req),
    .ch_ready (ch_ready),
    .wr       (wr_if)
);

for (genvar c = 0; c < `MPC_NUM_CH; c++)
begin : sub_buffer_gen
    xbar_sub_buffer u_xbar_sub_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_if[c]),
        .rd    (rd_if[c])
    );
end

xbar_bank_arbiter u_xbar_bank_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd_if),
    .bank_valid (bank_valid),
    .bank_req   (bank_req),
    .bank_src   (bank_src),
    .bank_ready (bank_ready)
);

// ------------------------------
// Bank side
// ------------------------------

assign bank_ready[0] = bank_0_ready;
assign bank_ready[1] = bank_1_ready;
assign bank_ready[2] = bank_2_ready;
assign bank_ready[3] = bank_3_ready;

assign bank_0_valid = bank_valid[0];
assign bank_0_op    = bank_req[0].op;
assign bank_0_addr  = bank_req[0].addr.raw;
assign bank_0_data  = bank_req[0].data;
assign bank_0_src   = bank_src[0];

assign bank_1_valid = bank_valid[1];
assign bank_1_op    = bank_req[1].op;
assign bank_1_addr  = bank_req[1].addr.raw;
assign bank_1_data  = bank_req[1].data;
assign bank_1_src   = bank_src[1];

assign bank_2_valid = bank_valid[2];
assign bank_2_op    = bank_req[2].op;
assign bank_2_addr  = bank_req[2].addr.raw;
assign bank_2_data  = bank_req[2].data;
assign bank_2_src   = bank_src[2];

assign bank_3_valid = bank_valid[3];
assign bank_3_op    = bank_req[3].op;
assign bank_3_addr  = bank_req[3].addr.raw;
assign bank_3_data  = bank_req[3].data;
assign bank_3_src   = bank_src[3];

endmodule

// File: source/xbar_bank_arbiter.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

module xbar_bank_arbiter
    import mpc_types::*, xbar_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,

    ch_rd_if.arbiter                      rd         [`MPC_NUM_CH],

    output logic                          bank_valid [`MPC_NUM_BANK],
    output mpc_req_t                      bank_req   [`MPC_NUM_BANK],
    output logic [$clog2(`MPC_NUM_CH)-1:0] bank_src  [`MPC_NUM_BANK],
    input  logic                          bank_ready [`MPC_NUM_BANK]
);

localparam int CH_ID_W = $clog2(`MPC_NUM_CH);

ch_1hot_t                  head_valid [`MPC_NUM_BANK];
entry_1hot_t               head_1hot  [`MPC_NUM_BANK][`MPC_NUM_CH];
mpc_req_t                  head_req   [`MPC_NUM_BANK][`MPC_NUM_CH];
ch_1hot_t                  grant      [`MPC_NUM_BANK];
logic [`MPC_NUM_BANK-1:0]  bank_hsk;

// Gather the heads and return the released entries.
for (genvar c = 0; c < `MPC_NUM_CH; c++)
begin : ch_gen
    entry_1hot_t rel;

    for (genvar b = 0; b < `MPC_NUM_BANK; b++)
    begin : head_gen
        assign head_valid[b][c] = rd[c].head_valid[b];
        assign head_1hot[b][c]  = rd[c].head_1hot[b];
        assign head_req[b][c]   = rd[c].head_req[b];
    end

    always_comb
    begin
        rel = '0;
        for (int b = 0; b < `MPC_NUM_BANK; b++)
        begin
            if (bank_hsk[b] && grant[b][c])
                rel = rel | head_1hot[b][c];
        end
    end

    assign rd[c].pop      = |rel;
    assign rd[c].pop_1hot = rel;
end

for (genvar b = 0; b < `MPC_NUM_BANK; b++)
begin : bank_gen
    logic [CH_ID_W-1:0] ptr_q;
    logic [CH_ID_W-1:0] ptr_nxt;
    logic [CH_ID_W-1:0] grant_idx;
    ch_1hot_t           grant_q;
    ch_1hot_t           pick;
    logic               lock_q;
    logic               valid;
    mpc_req_t           req_mux;

    // Scan from the pointer, so the channel at the pointer has top priority.
    always_comb
    begin : pick_comb
        int unsigned idx;
        pick = '0;
        for (int k = `MPC_NUM_CH - 1; k >= 0; k--)
        begin
            idx = (int'(ptr_q) + k) % `MPC_NUM_CH;
            if (head_valid[b][idx])
                pick = ch_1hot_t'(1) << idx;
        end
    end

    assign grant[b] = lock_q ? grant_q : pick;
    assign valid    = |(grant[b] & head_valid[b]);
    assign bank_hsk[b] = valid & bank_ready[b];

    always_comb
    begin
        req_mux   = '0;
        grant_idx = '0;
        for (int c = 0; c < `MPC_NUM_CH; c++)
        begin
            if (grant[b][c])
            begin
                req_mux   = head_req[b][c];
                grant_idx = CH_ID_W'(c);
            end
        end
    end

    assign ptr_nxt = (grant_idx == CH_ID_W'(`MPC_NUM_CH - 1)) ? '0 : grant_idx + 1'b1;

    // A stalled grant stays locked until its handshake.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr_q   <= '0;
            grant_q <= '0;
            lock_q  <= 1'b0;
        end
        else if (bank_hsk[b])
        begin
            ptr_q  <= ptr_nxt;
            lock_q <= 1'b0;
        end
        else if (valid)
        begin
            grant_q <= grant[b];
            lock_q  <= 1'b1;
        end
    end

    assign bank_valid[b] = valid;
    assign bank_req[b]   = req_mux;
    assign bank_src[b]   = grant_idx;
end

endmodule

// File: source/xbar_sub_buffer.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

module xbar_sub_buffer
    import mpc_types::*, xbar_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    ch_wr_if.buffer wr,
    ch_rd_if.buffer rd
);

mpc_req_t    req_q   [`MPC_BUF_DEPTH];
bank_id_t    bank_q  [`MPC_BUF_DEPTH];
entry_1hot_t valid_q;
// Bit j of row i is set when entry j arrived before entry i.
entry_1hot_t older_q [`MPC_BUF_DEPTH];

entry_1hot_t wr_mask;
entry_1hot_t rel_mask;

assign wr_mask  = wr.wen ? (entry_1hot_t'(1) << wr.w_entry_id) : '0;
assign rel_mask = rd.pop ? rd.pop_1hot : '0;
assign wr.free  = ~valid_q;

// ------------------------------
// Entry state
// ------------------------------

always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        valid_q <= '0;
        for (int i = 0; i < `MPC_BUF_DEPTH; i++)
            older_q[i] <= '0;
    end
    else
    begin
        valid_q <= (valid_q & ~rel_mask) | wr_mask;
        for (int i = 0; i < `MPC_BUF_DEPTH; i++)
        begin
            if (wr_mask[i])
                older_q[i] <= valid_q & ~rel_mask;
            else
                older_q[i] <= older_q[i] & ~rel_mask;
        end
    end
end

always_ff @(posedge clk)
begin
    for (int i = 0; i < `MPC_BUF_DEPTH; i++)
    begin
        if (wr_mask[i])
        begin
            req_q[i]  <= wr.w_req;
            bank_q[i] <= wr.w_bank;
        end
    end
end

// ------------------------------
// Per-bank head selection
// ------------------------------

for (genvar b = 0; b < `MPC_NUM_BANK; b++)
begin : bank_gen
    entry_1hot_t match;
    entry_1hot_t head;
    mpc_req_t    head_req;

    always_comb
    begin
        for (int i = 0; i < `MPC_BUF_DEPTH; i++)
            match[i] = valid_q[i] & (bank_q[i] == bank_id_t'(b));
    end

    // The head is the matching entry with no older match.
    always_comb
    begin
        head     = '0;
        head_req = '0;
        for (int i = 0; i < `MPC_BUF_DEPTH; i++)
        begin
            if (match[i] && !(|(older_q[i] & match)))
            begin
                head[i]  = 1'b1;
                head_req = req_q[i];
            end
        end
    end

    assign rd.head_valid[b] = |head;
    assign rd.head_1hot[b]  = head;
    assign rd.head_req[b]   = head_req;
end

endmodule

// File: source/xbar_ingress.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

module xbar_ingress
    import mpc_types::*, xbar_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     ch_valid [`MPC_NUM_CH],
    input  mpc_req_t ch_req   [`MPC_NUM_CH],
    output logic     ch_ready [`MPC_NUM_CH],

    ch_wr_if.ingress wr [`MPC_NUM_CH]
);

for (genvar c = 0; c < `MPC_NUM_CH; c++)
begin : ch_gen
    logic      hold_valid;
    mpc_req_t  hold_req;
    entry_id_t free_id;
    logic      push;

    // Lowest free entry wins.
    always_comb
    begin
        free_id = '0;
        for (int i = `MPC_BUF_DEPTH - 1; i >= 0; i--)
        begin
            if (wr[c].free[i])
                free_id = entry_id_t'(i);
        end
    end

    assign push        = hold_valid & (|wr[c].free);
    assign ch_ready[c] = ~hold_valid | push;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            hold_valid <= 1'b0;
        else if (ch_ready[c])
            hold_valid <= ch_valid[c];
    end

    always_ff @(posedge clk)
    begin
        if (ch_valid[c] && ch_ready[c])
            hold_req <= ch_req[c];
    end

    assign wr[c].wen        = push;
    assign wr[c].w_entry_id = free_id;
    assign wr[c].w_bank     = hold_req.addr.fld.bank;
    assign wr[c].w_req      = hold_req;
end

endmodule

// File: source/xbar_ifs.sv
`timescale 1ns/1ps

`include "mpc_params.svh"

// Write side of one channel buffer.
interface ch_wr_if
    import mpc_types::*, xbar_pkg::*;
();
    logic        wen;
    entry_id_t   w_entry_id;
    bank_id_t    w_bank;
    mpc_req_t    w_req;
    entry_1hot_t free;

    modport ingress (output wen, w_entry_id, w_bank, w_req, input free);
    modport buffer  (input wen, w_entry_id, w_bank, w_req, output free);
endinterface

// Read side of one channel buffer, one head per bank.
interface ch_rd_if
    import mpc_types::*, xbar_pkg::*;
();
    logic [`MPC_NUM_BANK-1:0] head_valid;
    entry_1hot_t              head_1hot [`MPC_NUM_BANK];
    mpc_req_t                 head_req  [`MPC_NUM_BANK];
    logic                     pop;
    entry_1hot_t              pop_1hot;

    modport buffer  (output head_valid, head_1hot, head_req, input pop, pop_1hot);
    modport arbiter (input head_valid, head_1hot, head_req, output pop, pop_1hot);
endinterface

// File: source/xbar_pkg.sv
package xbar_pkg;

`include "mpc_params.svh"

    // One bit per requester channel.
    typedef logic [`MPC_NUM_CH-1:0] ch_1hot_t;

    // One bit per buffer entry.
    typedef logic [`MPC_BUF_DEPTH-1:0] entry_1hot_t;

    typedef logic [$clog2(`MPC_BUF_DEPTH)-1:0] entry_id_t;

    typedef logic [$clog2(`MPC_NUM_BANK)-1:0] bank_id_t;

endpackage

// File: source/mpc_types.sv
package mpc_types;

`include "mpc_params.svh"

    typedef enum logic [`MPC_OP_W-1:0] {
        MPC_OP_READ     = 3'd0,
        MPC_OP_WRITE    = 3'd1,
        MPC_OP_FLUSH    = 3'd2,
        MPC_OP_INVAL    = 3'd3,
        MPC_OP_CLEAN    = 3'd4,
        MPC_OP_PREFETCH = 3'd5,
        MPC_OP_RSVD6    = 3'd6,
        MPC_OP_RSVD7    = 3'd7
    } mpc_op_e;

    // Bank sits between the set index and the line offset.
    typedef struct packed {
        logic [`MPC_TAG_W-1:0]    tag;
        logic [`MPC_SET_W-1:0]    set;
        logic [`MPC_BANK_W-1:0]   bank;
        logic [`MPC_OFFSET_W-1:0] offset;
    } mpc_addr_fields_t;

    typedef union packed {
        logic [`MPC_ADDR_W-1:0] raw;
        mpc_addr_fields_t       fld;
    } mpc_addr_u;

    typedef struct packed {
        mpc_op_e                op;
        mpc_addr_u              addr;
        logic [`MPC_DATA_W-1:0] data;
    } mpc_req_t;

endpackage

// File: source/mpc_params.svh
`ifndef MPC_PARAMS_SVH
`define MPC_PARAMS_SVH

// Crossbar dimensions.
`define MPC_NUM_CH      3
`define MPC_NUM_BANK    4
`define MPC_BUF_DEPTH   8

// Request fields. Tag, set, bank and offset add up to the address width.
`define MPC_OP_W        3
`define MPC_ADDR_W      32
`define MPC_DATA_W      128
`define MPC_TAG_W       20
`define MPC_SET_W       6
`define MPC_BANK_W      2
`define MPC_OFFSET_W    4

`endif
